// File: hdl/vcache_config.svh
// ########################################
// widths and sizes of the cache control path
// tag, index and offset must add up to the address width
// ########################################
`ifndef VCACHE_CONFIG_SVH
`define VCACHE_CONFIG_SVH

// request word, data and id widths
`define VCACHE_ADDR_W 16
`define VCACHE_DATA_W 16
`define VCACHE_ID_W 4

// address split into tag, set index and word offset
`define VCACHE_INDEX_W 3
`define VCACHE_OFFSET_W 2
`define VCACHE_TAG_W 11

// miss queue depth and profiler counter width
`define VCACHE_MISS_DEPTH 4
`define VCACHE_CTR_W 16

`endif

// File: hdl/vcache_pkg.sv
// ########################################
// shared types of the cache control path
// sized by the macros of the config header
// ########################################
`default_nettype none

package vcache_pkg;

  `include "vcache_config.svh"

  // field view of an address, tag in the upper bits
  typedef struct packed {
    logic [`VCACHE_TAG_W-1:0]    tag;
    logic [`VCACHE_INDEX_W-1:0]  index;
    logic [`VCACHE_OFFSET_W-1:0] offset;
  } vcache_addr_fields_s;

  // the DMA side sees the flat word, the lookup sees the fields
  typedef union packed {
    logic [`VCACHE_ADDR_W-1:0] flat;
    vcache_addr_fields_s       fields;
  } vcache_addr_u;

  // request from the core, also stored as a miss queue entry
  typedef struct packed {
    logic [`VCACHE_ID_W-1:0]   id;
    logic                      write_not_read;
    vcache_addr_u              addr;
    logic [`VCACHE_DATA_W-1:0] data;
  } vcache_req_s;

  typedef struct packed {
    logic [`VCACHE_ID_W-1:0] id;
    logic                    write_not_read;
    logic                    hit;
  } vcache_resp_s;

  typedef struct packed {
    logic                      write_not_read;
    logic [`VCACHE_ADDR_W-1:0] addr;
    logic [`VCACHE_DATA_W-1:0] data;
  } vcache_dma_pkt_s;

  // tag install for one set
  typedef struct packed {
    logic [`VCACHE_INDEX_W-1:0] index;
    logic [`VCACHE_TAG_W-1:0]   tag;
  } vcache_fill_s;

  typedef struct packed {
    logic [`VCACHE_CTR_W-1:0] ld_hit;
    logic [`VCACHE_CTR_W-1:0] st_hit;
    logic [`VCACHE_CTR_W-1:0] ld_hit_under_miss;
    logic [`VCACHE_CTR_W-1:0] st_hit_under_miss;
    logic [`VCACHE_CTR_W-1:0] ld_miss;
    logic [`VCACHE_CTR_W-1:0] st_miss;
    logic [`VCACHE_CTR_W-1:0] dma_read;
    logic [`VCACHE_CTR_W-1:0] dma_write;
  } vcache_stat_s;

endpackage

`default_nettype wire

// File: hdl/vcache_tag_lookup.sv
// ########################################
// direct-mapped tag lookup, response in the request cycle
// a fill in the lookup cycle is seen on the next cycle only
// ########################################
`timescale 1ns/100ps
`default_nettype none

`include "vcache_config.svh"

module vcache_tag_lookup (
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  vcache_pkg::vcache_req_s  req_i,
  input  logic                   req_v_i,
  output logic                   req_ready_o,

  output vcache_pkg::vcache_resp_s resp_o,
  output logic                   resp_v_o,
  input  logic                   resp_ready_i,

  output vcache_pkg::vcache_req_s  miss_o,
  output logic                   miss_v_o,
  input  logic                   miss_ready_i,

  input  vcache_pkg::vcache_fill_s fill_i,
  input  logic                   fill_v_i
);

  import vcache_pkg::*;

  localparam int SETS_LP = 2 ** `VCACHE_INDEX_W;

  logic [`VCACHE_TAG_W-1:0] tag_r [SETS_LP];
  logic [SETS_LP-1:0]       valid_r;

  logic [`VCACHE_INDEX_W-1:0] req_index;
  logic [`VCACHE_TAG_W-1:0]   req_tag;
  logic                       hit;

  assign req_index = req_i.addr.fields.index;
  assign req_tag   = req_i.addr.fields.tag;
  assign hit       = valid_r[req_index] & (tag_r[req_index] == req_tag);

  // the response goes out with the request, so both share one handshake
  assign resp_v_o              = req_v_i;
  assign resp_o.id             = req_i.id;
  assign resp_o.write_not_read = req_i.write_not_read;
  assign resp_o.hit            = hit;

  // a miss needs room in the queue, a hit only needs the response taken
  assign req_ready_o = resp_ready_i & (hit | miss_ready_i);

  assign miss_o   = req_i;
  assign miss_v_o = req_v_i & resp_ready_i & ~hit;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_i.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[fill_i.index] <= fill_i.tag;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vcache_miss_fifo.sv
// ########################################
// circular miss queue, one push and one pop per cycle
// ########################################
`timescale 1ns/100ps
`default_nettype none

module vcache_miss_fifo #(
  parameter int DEPTH_P = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  vcache_pkg::vcache_req_s data_i,
  input  logic                  v_i,
  output logic                  ready_o,

  output vcache_pkg::vcache_req_s data_o,
  output logic                  v_o,
  input  logic                  yumi_i,

  output logic                  empty_o
);

  import vcache_pkg::*;

  localparam int PTR_W_LP = (DEPTH_P > 1) ? $clog2(DEPTH_P) : 1;
  localparam int CNT_W_LP = $clog2(DEPTH_P + 1);
  localparam logic [PTR_W_LP-1:0] LAST_LP  = PTR_W_LP'(DEPTH_P - 1);
  localparam logic [CNT_W_LP-1:0] DEPTH_LP = CNT_W_LP'(DEPTH_P);

  vcache_req_s mem_r [DEPTH_P];

  logic [PTR_W_LP-1:0] wptr_r;
  logic [PTR_W_LP-1:0] rptr_r;
  logic [CNT_W_LP-1:0] count_r;
  logic                push;
  logic                pop;

  assign ready_o = (count_r != DEPTH_LP);
  assign v_o     = (count_r != '0);
  assign empty_o = (count_r == '0);
  assign data_o  = mem_r[rptr_r];

  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wptr_r <= (wptr_r == LAST_LP) ? '0 : wptr_r + 1'b1;
      end
      if (pop) begin
        rptr_r <= (rptr_r == LAST_LP) ? '0 : rptr_r + 1'b1;
      end
      // push and pop together leave the count unchanged
      if (push & ~pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop & ~push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vcache_mhu.sv
// ########################################
// holds one miss at a time and issues its DMA packet
// load misses fetch the whole line, store misses write one word
// ########################################
`timescale 1ns/100ps
`default_nettype none

module vcache_mhu (
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  vcache_pkg::vcache_req_s     miss_i,
  input  logic                      miss_v_i,
  output logic                      miss_yumi_o,

  output vcache_pkg::vcache_dma_pkt_s dma_pkt_o,
  output logic                      dma_v_o,
  input  logic                      dma_ready_i,

  output vcache_pkg::vcache_fill_s    fill_o,
  output logic                      fill_v_o,
  output logic                      busy_o
);

  import vcache_pkg::*;

  vcache_req_s  miss_r;
  logic         busy_r;
  vcache_addr_u line_addr;

  assign miss_yumi_o = miss_v_i & ~busy_r;
  assign dma_v_o     = busy_r;
  assign busy_o      = busy_r;

  always_comb begin
    line_addr                  = miss_r.addr;
    line_addr.fields.offset    = '0;
    dma_pkt_o.write_not_read   = miss_r.write_not_read;
    dma_pkt_o.addr             = miss_r.write_not_read ? miss_r.addr.flat : line_addr.flat;
    dma_pkt_o.data             = miss_r.write_not_read ? miss_r.data : '0;
  end

  // the tag is installed on the edge where the line read is accepted
  assign fill_v_o     = busy_r & dma_ready_i & ~miss_r.write_not_read;
  assign fill_o.index = miss_r.addr.fields.index;
  assign fill_o.tag   = miss_r.addr.fields.tag;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
    end else if (miss_yumi_o) begin
      busy_r <= 1'b1;
    end else if (busy_r & dma_ready_i) begin
      busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_yumi_o) begin
      miss_r <= miss_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vcache_profiler.sv
// ########################################
// saturating event counters with a snapshot on request
// the snapshot excludes events of the request's own cycle
// ########################################
`timescale 1ns/100ps
`default_nettype none

`include "vcache_config.svh"

module vcache_profiler (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     req_v_i,
  input  logic                     req_ready_i,
  input  logic                     req_write_not_read_i,
  input  logic                     req_hit_i,
  input  logic                     mhu_idle_i,

  input  logic                     dma_v_i,
  input  logic                     dma_ready_i,
  input  logic                     dma_write_not_read_i,

  input  logic                     print_stat_v_i,
  input  logic [`VCACHE_DATA_W-1:0] print_tag_i,
  output vcache_pkg::vcache_stat_s   stat_o,
  output logic [`VCACHE_DATA_W-1:0] stat_tag_o,
  output logic                     stat_v_o
);

  import vcache_pkg::*;

  vcache_stat_s              stat_r;
  vcache_stat_s              snap_r;
  logic [`VCACHE_DATA_W-1:0] snap_tag_r;
  logic                      snap_v_r;

  logic req_xfer;
  logic dma_xfer;
  logic ld_hit_inc;
  logic st_hit_inc;
  logic ld_miss_inc;
  logic st_miss_inc;

  assign req_xfer    = req_v_i & req_ready_i;
  assign dma_xfer    = dma_v_i & dma_ready_i;
  assign ld_hit_inc  = req_xfer & req_hit_i & ~req_write_not_read_i;
  assign st_hit_inc  = req_xfer & req_hit_i & req_write_not_read_i;
  assign ld_miss_inc = req_xfer & ~req_hit_i & ~req_write_not_read_i;
  assign st_miss_inc = req_xfer & ~req_hit_i & req_write_not_read_i;

  // counters stop at all ones instead of wrapping
  function automatic logic [`VCACHE_CTR_W-1:0] sat_inc(
    input logic [`VCACHE_CTR_W-1:0] ctr,
    input logic                     en
  );
    return (en && (ctr != '1)) ? ctr + 1'b1 : ctr;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stat_r <= '0;
    end else begin
      stat_r.ld_hit            <= sat_inc(stat_r.ld_hit, ld_hit_inc);
      stat_r.st_hit            <= sat_inc(stat_r.st_hit, st_hit_inc);
      stat_r.ld_hit_under_miss <= sat_inc(stat_r.ld_hit_under_miss, ld_hit_inc & ~mhu_idle_i);
      stat_r.st_hit_under_miss <= sat_inc(stat_r.st_hit_under_miss, st_hit_inc & ~mhu_idle_i);
      stat_r.ld_miss           <= sat_inc(stat_r.ld_miss, ld_miss_inc);
      stat_r.st_miss           <= sat_inc(stat_r.st_miss, st_miss_inc);
      stat_r.dma_read          <= sat_inc(stat_r.dma_read, dma_xfer & ~dma_write_not_read_i);
      stat_r.dma_write         <= sat_inc(stat_r.dma_write, dma_xfer & dma_write_not_read_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      snap_v_r <= 1'b0;
    end else begin
      snap_v_r <= print_stat_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (print_stat_v_i) begin
      snap_r     <= stat_r;
      snap_tag_r <= print_tag_i;
    end
  end

  assign stat_o     = snap_r;
  assign stat_tag_o = snap_tag_r;
  assign stat_v_o   = snap_v_r;

endmodule

`default_nettype wire

// File: hdl/vcache_top.sv
// ########################################
// cache control path: lookup, miss queue, MHU, profiler
// up to miss queue depth plus one misses can be outstanding
// ########################################
`timescale 1ns/100ps
`default_nettype none

`include "vcache_config.svh"

module vcache_top (
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  vcache_pkg::vcache_req_s     req_i,
  input  logic                      req_v_i,
  output logic                      req_ready_o,

  output vcache_pkg::vcache_resp_s    resp_o,
  output logic                      resp_v_o,
  input  logic                      resp_ready_i,

  output vcache_pkg::vcache_dma_pkt_s dma_pkt_o,
  output logic                      dma_v_o,
  input  logic                      dma_ready_i,

  input  logic                      print_stat_v_i,
  input  logic [`VCACHE_DATA_W-1:0]  print_tag_i,
  output vcache_pkg::vcache_stat_s    stat_o,
  output logic [`VCACHE_DATA_W-1:0]  stat_tag_o,
  output logic                      stat_v_o
);

  import vcache_pkg::*;

  vcache_req_s  miss;
  logic         miss_v;
  logic         miss_ready;
  vcache_req_s  q_data;
  logic         q_v;
  logic         q_yumi;
  logic         q_empty;
  vcache_fill_s fill;
  logic         fill_v;
  logic         mhu_busy;
  logic         mhu_idle;

  // no miss is outstanding once the queue and the MHU are both empty
  assign mhu_idle = q_empty & ~mhu_busy;

  vcache_tag_lookup u_tag_lookup (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .req_v_i      (req_v_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i),
    .miss_o       (miss),
    .miss_v_o     (miss_v),
    .miss_ready_i (miss_ready),
    .fill_i       (fill),
    .fill_v_i     (fill_v)
  );

  vcache_miss_fifo #(
    .DEPTH_P (`VCACHE_MISS_DEPTH)
  ) u_miss_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (miss),
    .v_i     (miss_v),
    .ready_o (miss_ready),
    .data_o  (q_data),
    .v_o     (q_v),
    .yumi_i  (q_yumi),
    .empty_o (q_empty)
  );

  vcache_mhu u_mhu (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .miss_i      (q_data),
    .miss_v_i    (q_v),
    .miss_yumi_o (q_yumi),
    .dma_pkt_o   (dma_pkt_o),
    .dma_v_o     (dma_v_o),
    .dma_ready_i (dma_ready_i),
    .fill_o      (fill),
    .fill_v_o    (fill_v),
    .busy_o      (mhu_busy)
  );

  vcache_profiler u_profiler (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .req_v_i              (req_v_i),
    .req_ready_i          (req_ready_o),
    .req_write_not_read_i (req_i.write_not_read),
    .req_hit_i            (resp_o.hit),
    .mhu_idle_i           (mhu_idle),
    .dma_v_i              (dma_v_o),
    .dma_ready_i          (dma_ready_i),
    .dma_write_not_read_i (dma_pkt_o.write_not_read),
    .print_stat_v_i       (print_stat_v_i),
    .print_tag_i          (print_tag_i),
    .stat_o               (stat_o),
    .stat_tag_o           (stat_tag_o),
    .stat_v_o             (stat_v_o)
  );

endmodule

`default_nettype wire

// File: verif/vcache_assertions.sv
// ########################################
// handshake checks on the cache top level
// attached to every vcache_top by bind
// ########################################
`timescale 1ns/100ps
`default_nettype none

`include "vcache_config.svh"

module vcache_assertions (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        req_v_i,
  input logic                        req_ready_i,
  input logic                        resp_v_i,
  input logic                        resp_ready_i,
  input vcache_pkg::vcache_dma_pkt_s dma_pkt_i,
  input logic                        dma_v_i,
  input logic                        dma_ready_i,
  input logic                        miss_v_i,
  input logic                        miss_ready_i,
  input logic                        q_v_i,
  input logic                        q_yumi_i
);

  // queue occupancy rebuilt from the push and pop handshakes
  int q_count;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      q_count <= 0;
    end else if ((miss_v_i && miss_ready_i) && !(q_v_i && q_yumi_i)) begin
      q_count <= q_count + 1;
    end else if (!(miss_v_i && miss_ready_i) && (q_v_i && q_yumi_i)) begin
      q_count <= q_count - 1;
    end
  end

  // a packet waiting for the DMA side must not change or vanish
  dma_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_v_i && !dma_ready_i |=> dma_v_i && $stable(dma_pkt_i))
    else $error("DMA packet changed while it was waiting");

  // the response and the request transfer on the same edge
  resp_with_req: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i && req_ready_i |-> resp_v_i && resp_ready_i)
    else $error("request accepted without its response being taken");

  no_push_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_v_i && miss_ready_i |-> q_count < `VCACHE_MISS_DEPTH)
    else $error("miss pushed while the miss queue was full");

endmodule

bind vcache_top vcache_assertions u_assertions (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .req_v_i      (req_v_i),
  .req_ready_i  (req_ready_o),
  .resp_v_i     (resp_v_o),
  .resp_ready_i (resp_ready_i),
  .dma_pkt_i    (dma_pkt_o),
  .dma_v_i      (dma_v_o),
  .dma_ready_i  (dma_ready_i),
  .miss_v_i     (miss_v),
  .miss_ready_i (miss_ready),
  .q_v_i        (q_v),
  .q_yumi_i     (q_yumi)
);

`default_nettype wire

// File: verif/vcache_tb.sv
// ########################################
// random traffic checked against a model of tags, miss order
// and profiler counts; the first mismatch ends the run
// ########################################
`timescale 1ns/100ps
`default_nettype none

`include "vcache_config.svh"

module vcache_tb;

  import vcache_pkg::*;

  localparam int NUM_REQ        = 400;
  localparam int TIMEOUT_CYCLES = NUM_REQ * 20;
  localparam int MAX_OUT        = `VCACHE_MISS_DEPTH + 1;
  localparam int SETS           = 2 ** `VCACHE_INDEX_W;
  localparam logic [`VCACHE_TAG_W-1:0] TAG_A   = 11'h2a5;
  localparam logic [`VCACHE_TAG_W-1:0] TAG_B   = 11'h013;
  // never produced by the random pool
  localparam logic [`VCACHE_TAG_W-1:0] TAG_FAR = 11'h7ff;

  logic                      clk;
  logic                      reset;
  vcache_req_s               req;
  logic                      req_v;
  logic                      req_ready;
  vcache_resp_s              resp;
  logic                      resp_v;
  logic                      resp_ready;
  vcache_dma_pkt_s           dma_pkt;
  logic                      dma_v;
  logic                      dma_ready;
  logic                      print_v;
  logic [`VCACHE_DATA_W-1:0] print_tag;
  vcache_stat_s              stat;
  logic [`VCACHE_DATA_W-1:0] stat_tag;
  logic                      stat_v;

  // model state
  logic [`VCACHE_TAG_W-1:0]  m_tag [SETS];
  logic                      m_valid [SETS];
  vcache_dma_pkt_s           exp_dma [$];
  vcache_stat_s              m_stat;
  vcache_stat_s              exp_snap;
  logic [`VCACHE_DATA_W-1:0] exp_snap_tag;
  logic                      exp_stat_v;
  int                        outstanding;
  logic [31:0]               lfsr;

  vcache_top DUT (
    .clk_i          (clk),
    .reset_i        (reset),
    .req_i          (req),
    .req_v_i        (req_v),
    .req_ready_o    (req_ready),
    .resp_o         (resp),
    .resp_v_o       (resp_v),
    .resp_ready_i   (resp_ready),
    .dma_pkt_o      (dma_pkt),
    .dma_v_o        (dma_v),
    .dma_ready_i    (dma_ready),
    .print_stat_v_i (print_v),
    .print_tag_i    (print_tag),
    .stat_o         (stat),
    .stat_tag_o     (stat_tag),
    .stat_v_o       (stat_v)
  );

  always #50 clk = ~clk;

  // Galois LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic vcache_req_s random_request(input int n);
    vcache_req_s r;
    r.id                 = `VCACHE_ID_W'(n);
    r.addr.fields.tag    = (rand_bits(1) == 32'd1) ? TAG_A : TAG_B;
    r.addr.fields.index  = `VCACHE_INDEX_W'(rand_bits(`VCACHE_INDEX_W));
    r.addr.fields.offset = `VCACHE_OFFSET_W'(rand_bits(`VCACHE_OFFSET_W));
    r.write_not_read     = (rand_bits(1) == 32'd1);
    r.data               = `VCACHE_DATA_W'(rand_bits(`VCACHE_DATA_W));
    return r;
  endfunction

  function automatic logic [`VCACHE_CTR_W-1:0] bump(input logic [`VCACHE_CTR_W-1:0] c);
    return c + `VCACHE_CTR_W'(1);
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_stats();
    check("stat_tag", 32'(exp_snap_tag), 32'(stat_tag));
    check("ld_hit", 32'(exp_snap.ld_hit), 32'(stat.ld_hit));
    check("st_hit", 32'(exp_snap.st_hit), 32'(stat.st_hit));
    check("ld_hit_under_miss", 32'(exp_snap.ld_hit_under_miss), 32'(stat.ld_hit_under_miss));
    check("st_hit_under_miss", 32'(exp_snap.st_hit_under_miss), 32'(stat.st_hit_under_miss));
    check("ld_miss", 32'(exp_snap.ld_miss), 32'(stat.ld_miss));
    check("st_miss", 32'(exp_snap.st_miss), 32'(stat.st_miss));
    check("dma_read", 32'(exp_snap.dma_read), 32'(stat.dma_read));
    check("dma_write", 32'(exp_snap.dma_write), 32'(stat.dma_write));
  endtask

  // inputs are set at the falling edge; compare after they settle, then
  // advance the model over the next rising edge
  task automatic step_cycle(output logic accepted);
    logic                       hit;
    logic                       req_xfer;
    logic                       dma_xfer;
    logic [`VCACHE_INDEX_W-1:0] idx;
    vcache_dma_pkt_s            pkt;
    vcache_addr_u               line;
    #10;
    idx = req.addr.fields.index;
    hit = m_valid[idx] && (m_tag[idx] == req.addr.fields.tag);
    check("resp_v", 32'(req_v), 32'(resp_v));
    check("stat_v", 32'(exp_stat_v), 32'(stat_v));
    if (exp_stat_v) begin
      compare_stats();
    end
    if (req_v) begin
      check("resp_id", 32'(req.id), 32'(resp.id));
      check("resp_write_not_read", 32'(req.write_not_read), 32'(resp.write_not_read));
      check("resp_hit", 32'(hit), 32'(resp.hit));
      if (!resp_ready || (!hit && outstanding >= MAX_OUT)) begin
        check("req_ready_stalled", 32'd0, 32'(req_ready));
      end else if (hit) begin
        check("req_ready_hit", 32'd1, 32'(req_ready));
      end
    end
    if (dma_v && exp_dma.size() == 0) begin
      stop_with_error("DMA packet offered while no miss was outstanding");
    end
    if (print_v) begin
      exp_snap     = m_stat;
      exp_snap_tag = print_tag;
    end
    req_xfer = req_v && req_ready;
    dma_xfer = dma_v && dma_ready;

    // requests see the tags as they stand before the edge
    if (req_xfer && hit) begin
      if (req.write_not_read) begin
        m_stat.st_hit = bump(m_stat.st_hit);
        if (outstanding > 0) m_stat.st_hit_under_miss = bump(m_stat.st_hit_under_miss);
      end else begin
        m_stat.ld_hit = bump(m_stat.ld_hit);
        if (outstanding > 0) m_stat.ld_hit_under_miss = bump(m_stat.ld_hit_under_miss);
      end
    end else if (req_xfer) begin
      line = req.addr;
      pkt.write_not_read = req.write_not_read;
      if (req.write_not_read) begin
        m_stat.st_miss = bump(m_stat.st_miss);
        pkt.addr = req.addr.flat;
        pkt.data = req.data;
      end else begin
        m_stat.ld_miss = bump(m_stat.ld_miss);
        line.fields.offset = '0;
        pkt.addr = line.flat;
        pkt.data = '0;
      end
      exp_dma.push_back(pkt);
      outstanding++;
    end

    // fills from accepted line reads land after the lookup
    if (dma_xfer) begin
      pkt = exp_dma.pop_front();
      check("dma_write_not_read", 32'(pkt.write_not_read), 32'(dma_pkt.write_not_read));
      check("dma_addr", 32'(pkt.addr), 32'(dma_pkt.addr));
      outstanding--;
      if (pkt.write_not_read) begin
        check("dma_data", 32'(pkt.data), 32'(dma_pkt.data));
        m_stat.dma_write = bump(m_stat.dma_write);
      end else begin
        line.flat = pkt.addr;
        m_tag[line.fields.index]   = line.fields.tag;
        m_valid[line.fields.index] = 1'b1;
        m_stat.dma_read = bump(m_stat.dma_read);
      end
    end
    exp_stat_v = print_v;
    accepted = req_xfer;
    @(negedge clk);
  endtask

  task automatic run_random();
    int   issued;
    int   cyc;
    logic acc;
    issued = 0;
    cyc = 0;
    while (issued < NUM_REQ || req_v) begin
      resp_ready = (rand_bits(3) != 0);
      // every 64 cycles the DMA side stalls for 16
      dma_ready = ((cyc % 64) < 48) && (rand_bits(2) != 0);
      if (!req_v && issued < NUM_REQ && rand_bits(2) != 0) begin
        req = random_request(issued);
        req_v = 1'b1;
        issued++;
      end
      step_cycle(acc);
      if (acc) req_v = 1'b0;
      cyc++;
    end
  endtask

  task automatic drain();
    logic acc;
    req_v = 1'b0;
    dma_ready = 1'b1;
    while (exp_dma.size() != 0) begin
      step_cycle(acc);
    end
    step_cycle(acc);
  endtask

  // DMA stalled: count the misses taken, then offer a hit
  task automatic check_backpressure();
    logic acc;
    int   taken;
    int   hit_idx;
    taken = 0;
    hit_idx = -1;
    for (int i = 0; i < SETS; i++) begin
      if (hit_idx < 0 && m_valid[`VCACHE_INDEX_W'(i)]) hit_idx = i;
    end
    dma_ready = 1'b0;
    resp_ready = 1'b1;
    req_v = 1'b1;
    for (int c = 0; c < 3 * MAX_OUT; c++) begin
      req = '0;
      req.id = `VCACHE_ID_W'(taken);
      req.addr.fields.tag = TAG_FAR;
      req.addr.fields.index = `VCACHE_INDEX_W'(taken);
      step_cycle(acc);
      if (acc) taken++;
    end
    check("misses_taken_with_dma_stalled", 32'(MAX_OUT), 32'(taken));
    if (hit_idx < 0) begin
      stop_with_error("no valid line was left to test a hit under back-pressure");
    end else begin
      req = '0;
      req.id = `VCACHE_ID_W'(hit_idx);
      req.addr.fields.index = `VCACHE_INDEX_W'(hit_idx);
      req.addr.fields.tag = m_tag[`VCACHE_INDEX_W'(hit_idx)];
      step_cycle(acc);
      check("hit_taken_with_dma_stalled", 32'd1, 32'(acc));
      req_v = 1'b0;
    end
  endtask

  task automatic request_stats();
    logic acc;
    req_v = 1'b0;
    print_v = 1'b1;
    print_tag = `VCACHE_DATA_W'(16'hc0de);
    step_cycle(acc);
    print_v = 1'b0;
    // the snapshot is compared inside this cycle
    step_cycle(acc);
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    stop_with_error("watchdog ran out before the test finished");
  end

  initial begin
    logic acc;
    clk = 1'b0;
    reset = 1'b1;
    req = '0;
    req_v = 1'b0;
    resp_ready = 1'b0;
    dma_ready = 1'b0;
    print_v = 1'b0;
    print_tag = '0;
    lfsr = 32'h5ed4_d701;
    for (int i = 0; i < SETS; i++) begin
      m_tag[i] = '0;
      m_valid[i] = 1'b0;
    end
    m_stat = '0;
    exp_snap = '0;
    exp_snap_tag = '0;
    exp_stat_v = 1'b0;
    outstanding = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) step_cycle(acc);
    run_random();
    drain();
    check_backpressure();
    drain();
    request_stats();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/vcache_pkg.sv
hdl/vcache_tag_lookup.sv
hdl/vcache_miss_fifo.sv
hdl/vcache_mhu.sv
hdl/vcache_profiler.sv
hdl/vcache_top.sv
verif/vcache_assertions.sv
verif/vcache_tb.sv

// File: Makefile
# Verilator build and run of the cache control path testbench
# the run's exit status is the test result

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f tb.f --top-module vcache_tb -Mdir obj_dir -o vcache_sim
	./obj_dir/vcache_sim

clean:
	rm -rf obj_dir
